/* front_pkg.sv */
// Shared widths, RV32I opcode constants and enums for the fetch/decode front end
package front_pkg;

    // ------------------------------------------------
    // Datapath widths
    // ------------------------------------------------

    // PC and SRAM address width
    localparam int PC_WD = 32;

    // Instruction word width
    localparam int INST_WD = 32;

    // ------------------------------------------------
    // RV32I major opcodes seen by the pre-decoder
    // ------------------------------------------------

    // J-type jump and link
    localparam logic [6:0] OPC_JAL = 7'b110_1111;

    // B-type conditional branches, all six funct3 variants
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

    // I-type indirect jump, target not known in decode
    localparam logic [6:0] OPC_JALR = 7'b110_0111;

    // ------------------------------------------------
    // Decoded control-flow class
    // ------------------------------------------------

    // Travels downstream on out_class
    // OP_SEQ covers everything without a control-flow effect
    typedef enum logic [1:0] {
        OP_SEQ    = 2'd0,
        OP_JAL    = 2'd1,
        OP_BRANCH = 2'd2,
        OP_JALR   = 2'd3
    } op_class_t;

    // ------------------------------------------------
    // Decode stage slot occupancy
    // ------------------------------------------------

    // DS_EMPTY  no instruction in the slot
    // DS_HOLD   valid instruction, offered downstream
    // DS_KILL   slot dropped by a flush, drains in one cycle
    typedef enum logic [1:0] {
        DS_EMPTY = 2'd0,
        DS_HOLD  = 2'd1,
        DS_KILL  = 2'd2
    } ds_state_t;

endpackage

/* fetch_stage.sv */
// Fetch stage: next-PC selection, instruction SRAM request and the IF valid/PC registers
`timescale 1ns/100ps

module fetch_stage import front_pkg::*; #(
    parameter logic [PC_WD-1:0] reset_pc = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               ds_allowin,
    input  logic               br_taken,
    input  logic [PC_WD-1:0]   br_target,
    input  logic               inst_ready,
    input  logic [INST_WD-1:0] inst_rdata,
    input  logic               flush,
    input  logic [PC_WD-1:0]   flush_pc,
    output logic               fs_to_ds_valid,
    output logic [PC_WD-1:0]   fs_pc,
    output logic [INST_WD-1:0] fs_inst,
    output logic               inst_en,
    output logic [PC_WD-1:0]   inst_addr
);

    logic               fs_valid;
    logic               fs_allowin;
    logic               req_accept;
    logic               redirect;
    logic [PC_WD-1:0]   seq_pc;
    logic [PC_WD-1:0]   nextpc;
    // Redirect seen while the SRAM could not take the request
    logic               redir_pending;
    logic [PC_WD-1:0]   redir_pc;
    // Read data on the SRAM port belongs to fs_pc this cycle
    logic               rdata_fresh;
    logic [INST_WD-1:0] inst_buf;

    // ------------------------------------------------
    // Pre-IF, next PC and SRAM request
    // ------------------------------------------------

    assign redirect = flush | br_taken;
    assign seq_pc   = fs_pc + 32'd4;

    // Flush beats decode redirect, a parked redirect beats PC+4
    always_comb begin
        if (flush) begin
            nextpc = flush_pc;
        end else if (br_taken) begin
            nextpc = br_target;
        end else if (redir_pending) begin
            nextpc = redir_pc;
        end else begin
            nextpc = seq_pc;
        end
    end

    assign inst_en    = ~reset & fs_allowin;
    assign inst_addr  = nextpc;
    assign req_accept = inst_en & inst_ready;

    // Keep a redirect until the SRAM accepts its address
    always_ff @(posedge clk) begin
        if (reset) begin
            redir_pending <= 1'b0;
        end else if (redirect) begin
            redir_pending <= ~req_accept;
        end else if (req_accept) begin
            redir_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (redirect) begin
            redir_pc <= nextpc;
        end
    end

    // ------------------------------------------------
    // IF stage
    // ------------------------------------------------

    // Stage has no multi-cycle work, only waits on decode
    assign fs_allowin = ~fs_valid | ds_allowin;

    // Wrong-path word dropped in a redirect cycle
    assign fs_to_ds_valid = fs_valid & ~br_taken & ~flush;

    // A redirect empties the stage even when decode is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin || redirect) begin
            fs_valid <= req_accept;
        end
    end

    // First sequential address after reset is reset_pc
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= reset_pc - 32'd4;
        end else if (req_accept) begin
            fs_pc <= nextpc;
        end
    end

    // SRAM word only valid one cycle after the request
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_fresh <= 1'b0;
        end else begin
            rdata_fresh <= req_accept;
        end
    end

    // Hold the word while decode stalls
    always_ff @(posedge clk) begin
        if (rdata_fresh) begin
            inst_buf <= inst_rdata;
        end
    end

    assign fs_inst = rdata_fresh ? inst_rdata : inst_buf;

endmodule

/* decode_stage.sv */
// Decode stage: one-instruction slot, control-flow pre-decode and static branch redirect
`timescale 1ns/100ps

module decode_stage import front_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_to_ds_valid,
    input  logic [PC_WD-1:0]   fs_pc,
    input  logic [INST_WD-1:0] fs_inst,
    input  logic               out_allowin,
    input  logic               flush,
    output logic               ds_allowin,
    output logic               br_taken,
    output logic [PC_WD-1:0]   br_target,
    output logic               out_valid,
    output logic [PC_WD-1:0]   out_pc,
    output logic [INST_WD-1:0] out_inst,
    output op_class_t          out_class,
    output logic [31:0]        out_imm
);

    ds_state_t          ds_state;
    ds_state_t          ds_state_nxt;
    logic               ds_valid;
    logic               ds_load;
    logic [PC_WD-1:0]   ds_pc;
    logic [INST_WD-1:0] ds_inst;
    logic [6:0]         opcode;
    op_class_t          ds_class;
    logic [31:0]        j_imm;
    logic [31:0]        b_imm;
    logic [31:0]        i_imm;
    logic [31:0]        ds_imm;
    logic               redirect;

    // ------------------------------------------------
    // Slot occupancy and flow control
    // ------------------------------------------------

    assign ds_valid = (ds_state == DS_HOLD);

    // Single cycle decode, so only downstream back-pressure stalls
    assign ds_allowin = ~ds_valid | out_allowin;

    // Masked fetch valid means nothing enters during a flush
    assign ds_load = ds_allowin & fs_to_ds_valid;

    always_comb begin
        ds_state_nxt = ds_state;
        case (ds_state)
            DS_EMPTY, DS_KILL: begin
                ds_state_nxt = fs_to_ds_valid ? DS_HOLD : DS_EMPTY;
            end
            DS_HOLD: begin
                if (out_allowin) begin
                    ds_state_nxt = fs_to_ds_valid ? DS_HOLD : DS_EMPTY;
                end
            end
            default: begin
                ds_state_nxt = DS_EMPTY;
            end
        endcase
        // Flushed slot drops whatever it held
        if (flush) begin
            ds_state_nxt = DS_KILL;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_state <= DS_EMPTY;
        end else begin
            ds_state <= ds_state_nxt;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (ds_load) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    // ------------------------------------------------
    // Pre-decode
    // ------------------------------------------------

    assign opcode = ds_inst[6:0];

    always_comb begin
        case (opcode)
            OPC_JAL:    ds_class = OP_JAL;
            OPC_BRANCH: ds_class = OP_BRANCH;
            OPC_JALR:   ds_class = OP_JALR;
            default:    ds_class = OP_SEQ;
        endcase
    end

    // J-type offset, bit 0 always zero
    assign j_imm = {{12{ds_inst[31]}}, ds_inst[19:12], ds_inst[20],
                    ds_inst[30:21], 1'b0};

    // B-type offset
    assign b_imm = {{20{ds_inst[31]}}, ds_inst[7], ds_inst[30:25],
                    ds_inst[11:8], 1'b0};

    // I-type offset for jalr
    assign i_imm = {{20{ds_inst[31]}}, ds_inst[31:20]};

    always_comb begin
        case (ds_class)
            OP_JAL:    ds_imm = j_imm;
            OP_BRANCH: ds_imm = b_imm;
            OP_JALR:   ds_imm = i_imm;
            default:   ds_imm = 32'd0;
        endcase
    end

    // ------------------------------------------------
    // Redirect
    // ------------------------------------------------

    // Backward-taken prediction, sign bit of the B offset decides
    assign redirect = (ds_class == OP_JAL) | ((ds_class == OP_BRANCH) & b_imm[31]);

    // Only meaningful for jal and branch
    assign br_target = ds_pc + ds_imm;

    // Fires on the transfer cycle only
    assign br_taken = ds_valid & out_allowin & redirect;

    // Downstream
    assign out_valid = ds_valid;
    assign out_pc    = ds_pc;
    assign out_inst  = ds_inst;
    assign out_class = ds_class;
    assign out_imm   = ds_imm;

endmodule

/* front_end_top.sv */
// Front end top level: fetch and decode stages between the instruction SRAM and downstream
`timescale 1ns/100ps

module front_end_top import front_pkg::*; #(
    parameter logic [PC_WD-1:0] reset_pc = 32'h8000_0000
) (
    input  logic               clk,
    input  logic               reset,
    // Instruction SRAM, one cycle read latency
    output logic               inst_en,
    output logic [PC_WD-1:0]   inst_addr,
    input  logic               inst_ready,
    input  logic [INST_WD-1:0] inst_rdata,
    // Downstream pipeline
    output logic               out_valid,
    output logic [PC_WD-1:0]   out_pc,
    output logic [INST_WD-1:0] out_inst,
    output op_class_t          out_class,
    output logic [31:0]        out_imm,
    input  logic               out_allowin,
    // Flush from a later stage
    input  logic               flush,
    input  logic [PC_WD-1:0]   flush_pc
);

    // Fetch to decode
    logic               fs_to_ds_valid;
    logic [PC_WD-1:0]   fs_pc;
    logic [INST_WD-1:0] fs_inst;
    // Decode to fetch
    logic               ds_allowin;
    logic               br_taken;
    logic [PC_WD-1:0]   br_target;

    fetch_stage #(
        .reset_pc       (reset_pc)
    ) u_fetch (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .inst_ready     (inst_ready),
        .inst_rdata     (inst_rdata),
        .flush          (flush),
        .flush_pc       (flush_pc),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .inst_en        (inst_en),
        .inst_addr      (inst_addr)
    );

    decode_stage u_decode (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (fs_inst),
        .out_allowin    (out_allowin),
        .flush          (flush),
        .ds_allowin     (ds_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_inst       (out_inst),
        .out_class      (out_class),
        .out_imm        (out_imm)
    );

endmodule

/* front_end_properties.sv */
// Pipeline control assertions bound to front_end_top in the front end testbench
`timescale 1ns/100ps

module front_end_properties import front_pkg::*; (
    input logic               clk,
    input logic               reset,
    input logic               inst_en,
    input logic               out_valid,
    input logic               out_allowin,
    input logic [PC_WD-1:0]   out_pc,
    input logic [INST_WD-1:0] out_inst,
    input logic               flush,
    input ds_state_t          ds_state
);

    // Synchronous reset leaves the output idle from the next cycle
    reset_clears_out_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // No SRAM request while in reset
    no_fetch_in_reset: assert property (@(posedge clk) reset |-> !inst_en)
        else $error("inst_en high during reset");

    // Stalled output keeps its payload unless a flush drops it
    stall_holds_output: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin && !flush |=>
            out_valid && $stable(out_pc) && $stable(out_inst))
        else $error("out_pc or out_inst changed while stalled");

    // Nothing older than a flush is offered downstream
    flush_drops_output: assert property (@(posedge clk) disable iff (reset)
        flush |=> !out_valid)
        else $error("out_valid high in the cycle after flush");

    // Killed slot frees fetch to request the flush target
    kill_restarts_fetch: assert property (@(posedge clk) disable iff (reset)
        ds_state == DS_KILL |-> inst_en)
        else $error("no SRAM request while the decode slot drains");

endmodule

bind front_end_top front_end_properties u_props (
    .clk         (clk),
    .reset       (reset),
    .inst_en     (inst_en),
    .out_valid   (out_valid),
    .out_allowin (out_allowin),
    .out_pc      (out_pc),
    .out_inst    (out_inst),
    .flush       (flush),
    .ds_state    (u_decode.ds_state)
);

/* tb_front_end.sv */
// Front end testbench: SRAM model and expected outputs from the trace file, random stalls, checks
`timescale 1ns/100ps

module tb_front_end import front_pkg::*; ();

    localparam logic [PC_WD-1:0]   start_pc    = 32'h8000_0000;
    localparam int                 out_timeout = 200;
    localparam logic [INST_WD-1:0] nop_inst    = 32'h0000_0013;

    logic               clk = 1'b0;
    logic               reset;
    logic               inst_en;
    logic [PC_WD-1:0]   inst_addr;
    logic               inst_ready;
    logic [INST_WD-1:0] inst_rdata = 32'h0000_0013;
    logic               out_valid;
    logic [PC_WD-1:0]   out_pc;
    logic [INST_WD-1:0] out_inst;
    op_class_t          out_class;
    logic [31:0]        out_imm;
    logic               out_allowin;
    logic               flush;
    logic [PC_WD-1:0]   flush_pc;

    // Trace contents
    logic [31:0] prog_mem [logic [31:0]];
    logic [31:0] exp_pc_q [$];
    logic [31:0] exp_inst_q [$];
    int          flush_after_q [$];
    logic [31:0] flush_pc_q [$];

    // Output captured on a transfer edge
    logic [31:0] got_pc;
    logic [31:0] got_inst;
    logic [31:0] got_imm;
    logic [1:0]  got_class;

    logic [31:0] lcg_state    = 32'hb083_6a4b;
    logic        load_ok      = 1'b1;
    logic        timed_out    = 1'b0;
    int          tests        = 0;
    int          failed_tests = 0;
    int          errors       = 0;

    // 8 ns clock
    always #4 clk = ~clk;

    front_end_top #(
        .reset_pc    (start_pc)
    ) UUT (
        .clk         (clk),
        .reset       (reset),
        .inst_en     (inst_en),
        .inst_addr   (inst_addr),
        .inst_ready  (inst_ready),
        .inst_rdata  (inst_rdata),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst    (out_inst),
        .out_class   (out_class),
        .out_imm     (out_imm),
        .out_allowin (out_allowin),
        .flush       (flush),
        .flush_pc    (flush_pc)
    );

    // --------------------------------------------------
    // Instruction SRAM model
    // --------------------------------------------------

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (prog_mem.exists(addr)) begin
            return prog_mem[addr];
        end
        // Unloaded space reads as nop
        return nop_inst;
    endfunction

    // One cycle read latency, word held until the next accepted request
    always @(posedge clk) begin
        if (inst_en && inst_ready) begin
            inst_rdata <= fetch_word(inst_addr);
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Reference pre-decode, straight from the RV32I formats
    function automatic void classify(input logic [31:0] inst, output logic [1:0] cls,
                                     output logic [31:0] imm);
        logic [20:0] off_j;
        logic [12:0] off_b;
        cls = OP_SEQ;
        imm = 32'd0;
        off_j = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        off_b = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        if (inst[6:0] == OPC_JAL) begin
            cls = OP_JAL;
            imm = {{11{off_j[20]}}, off_j};
        end else if (inst[6:0] == OPC_BRANCH) begin
            cls = OP_BRANCH;
            imm = {{19{off_b[12]}}, off_b};
        end else if (inst[6:0] == OPC_JALR) begin
            cls = OP_JALR;
            imm = {{20{inst[31]}}, inst[31:20]};
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Next cycle inputs, outputs blocked while flush is up
    task automatic drive_cycle(input logic do_flush, input logic [31:0] target);
        logic [31:0] r;
        r = lcg_next();
        inst_ready <= (r[31:30] != 2'b00);
        flush      <= do_flush;
        if (do_flush) begin
            flush_pc    <= target;
            out_allowin <= 1'b0;
        end else begin
            out_allowin <= (r[29:28] != 2'b00);
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        int          cnt;
        string       line;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("front_end_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open front_end_trace.txt for reading");
            load_ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1) begin
                rest = line.substr(1, line.len() - 1);
                case (line.getc(0))
                    "M": begin
                        n = $sscanf(rest, "%h %h", a, b);
                        prog_mem[a] = b;
                    end
                    "F": begin
                        n = $sscanf(rest, "%d %h", cnt, b);
                        flush_after_q.push_back(cnt);
                        flush_pc_q.push_back(b);
                    end
                    "E": begin
                        n = $sscanf(rest, "%h %h", a, b);
                        exp_pc_q.push_back(a);
                        exp_inst_q.push_back(b);
                    end
                    // Comments and blank lines
                    default: ;
                endcase
            end
        end
        $fclose(fd);
    endtask

    // Wait for one downstream transfer, keep stalls going meanwhile
    task automatic wait_output(input int idx);
        int   cycles;
        logic got;
        cycles = 0;
        got = 1'b0;
        while (!got && !timed_out) begin
            @(posedge clk);
            got = out_valid & out_allowin;
            if (got) begin
                got_pc    = out_pc;
                got_inst  = out_inst;
                got_imm   = out_imm;
                got_class = out_class;
            end else begin
                cycles++;
                drive_cycle(1'b0, 32'd0);
                if (cycles >= out_timeout) begin
                    $display("Timeout: output %0d was not accepted within %0d cycles",
                             idx + 1, out_timeout);
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------

    initial begin
        logic [1:0]  exp_class;
        logic [31:0] exp_imm;
        logic [31:0] model_pc;
        int          errors_before;
        reset       <= 1'b1;
        inst_ready  <= 1'b0;
        out_allowin <= 1'b0;
        flush       <= 1'b0;
        flush_pc    <= 32'd0;
        load_trace();
        if (load_ok && exp_pc_q.size() == 0) begin
            $display("Trace file holds no expected outputs");
            load_ok = 1'b0;
        end
        repeat (10) begin
            @(posedge clk);
            drive_cycle(1'b0, 32'd0);
        end
        reset <= 1'b0;
        model_pc = start_pc;
        for (int i = 0; i < exp_pc_q.size() && load_ok && !timed_out; i++) begin
            wait_output(i);
            if (!timed_out) begin
                errors_before = errors;
                classify(exp_inst_q[i], exp_class, exp_imm);
                check_value("out_pc", got_pc, exp_pc_q[i]);
                check_value("out_inst", got_inst, exp_inst_q[i]);
                check_value("out_class", {30'd0, got_class}, {30'd0, exp_class});
                check_value("out_imm", got_imm, exp_imm);
                // Independent next-PC model, catches a wrong E list too
                check_value("out_pc vs next-pc model", got_pc, model_pc);
                tests++;
                if (errors != errors_before) begin
                    failed_tests++;
                end
                $display("Test %0d pc %h class %0d: %s", i + 1, got_pc, got_class,
                         (errors == errors_before) ? "pass" : "fail");
                // Static prediction, backward branches and jal redirect
                if (exp_class == OP_JAL || (exp_class == OP_BRANCH && exp_imm[31])) begin
                    model_pc = exp_pc_q[i] + exp_imm;
                end else begin
                    model_pc = exp_pc_q[i] + 32'd4;
                end
                if (flush_after_q.size() > 0 && flush_after_q[0] == i + 1) begin
                    drive_cycle(1'b1, flush_pc_q[0]);
                    model_pc = flush_pc_q[0];
                    flush_after_q.delete(0);
                    flush_pc_q.delete(0);
                end else begin
                    drive_cycle(1'b0, 32'd0);
                end
            end
        end
        $display("Done: %0d tests, %0d failed, %0d value mismatches",
                 tests, failed_tests, errors);
        if (load_ok && !timed_out && failed_tests == 0 && tests == exp_pc_q.size()) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* front_end_trace.txt */
# M <addr> <word>      program word, both hex
# F <count> <flush_pc> flush after <count> accepted outputs (decimal), flush_pc hex
# E <pc> <inst>        expected downstream output in order, both hex
M 80000000 00100093
M 80000004 00200113
M 80000008 0100006f
M 8000000c 00300193
M 80000010 00400193
M 80000014 00500193
M 80000018 00400213
M 8000001c 00000663
M 80000020 00808067
M 80000024 00500293
M 80000028 fe029ee3
M 8000002c 00600313
M 80000040 12345337
M 80000044 00c000ef
M 80000048 00800413
M 8000004c 00900493
M 80000050 00700393
M 80000054 ff5ff06f
F 12 80000040
F 20 80000100
E 80000000 00100093
E 80000004 00200113
E 80000008 0100006f
E 80000018 00400213
E 8000001c 00000663
E 80000020 00808067
E 80000024 00500293
E 80000028 fe029ee3
E 80000024 00500293
E 80000028 fe029ee3
E 80000024 00500293
E 80000028 fe029ee3
E 80000040 12345337
E 80000044 00c000ef
E 80000050 00700393
E 80000054 ff5ff06f
E 80000048 00800413
E 8000004c 00900493
E 80000050 00700393
E 80000054 ff5ff06f
E 80000100 00000013
E 80000104 00000013

/* tb.f */
front_pkg.sv
fetch_stage.sv
decode_stage.sv
front_end_top.sv
front_end_properties.sv
tb_front_end.sv

/* Makefile */
# Verilator build and run of the front end testbench

TOP = tb_front_end
BUILD = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove the build directory and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir $(BUILD) -o sim_$(TOP)
	./$(BUILD)/sim_$(TOP) | tee sim.log
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log
